// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = i2c_master_tb
FILE_LIST  = all.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+source
source/i2c_pkg.sv
source/i2c_phase_timer.sv
source/i2c_sequencer.sv
source/i2c_bit_engine.sv
source/i2c_master.sv
test/i2c_slave_model.sv
test/i2c_master_props.sv
test/i2c_master_tb.sv

// ==== source/i2c_bit_engine.sv ====
`include "i2c_config.svh"

module i2c_bit_engine (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            tick,
    input  i2c_pkg::phase_t                 phase,
    input  i2c_pkg::bit_op_t                bit_op,
    input  logic                            tx_bit,
    input  logic [$clog2(`I2C_BYTE_BITS):0] read_index,
    input  logic                            sda_in,
    output logic                            scl_level,
    output logic                            scl_oe,
    output logic                            sda_level,
    output logic                            sda_oe,
    output logic                            rx_bit,
    output i2c_pkg::byte_word_t             miso_data
);
    import i2c_pkg::*;

    localparam int COUNT_BITS = $clog2(`I2C_BYTE_BITS);

    logic scl_next;
    logic sda_next;
    logic clock_high;
    logic sample;

    // Ordinary bits keep the clock high in phases 1 and 2
    assign clock_high = (phase == 2'd1) || (phase == 2'd2);
    assign sample = tick && (phase == 2'd2);

    ////////////////////////////////////////////////////////////////////////////
    // Line waveforms per bit kind
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        scl_next = 1'b1;
        sda_next = 1'b1;
        case (bit_op)
            OP_START: begin
                // Data falls in phase 1 with the clock high
                scl_next = (phase != 2'd3);
                sda_next = (phase == 2'd0);
            end
            OP_RESTART: begin
                scl_next = (phase != 2'd0);
            end
            OP_STOP: begin
                // Data rises in phase 2 with the clock high
                scl_next = (phase != 2'd0);
                sda_next = phase[1];
            end
            OP_SEND: begin
                scl_next = clock_high;
                sda_next = tx_bit;
            end
            OP_RECEIVE, OP_MASTER_NACK: begin
                scl_next = clock_high;
            end
            OP_MASTER_ACK: begin
                scl_next = clock_high;
                sda_next = 1'b0;
            end
            default: begin
                scl_next = 1'b1;
                sda_next = 1'b1;
            end
        endcase
    end

    // Open drain, a high level just releases the line
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            scl_level <= 1'b1;
            sda_level <= 1'b1;
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end else begin
            scl_level <= scl_next;
            sda_level <= sda_next;
            scl_oe <= !scl_next;
            sda_oe <= !sda_next;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rx_bit <= 1'b1;
            miso_data <= '0;
        end else if (sample) begin
            rx_bit <= sda_in;
            if (bit_op == OP_RECEIVE) begin
                if (read_index[COUNT_BITS]) begin
                    miso_data.bytes.high[read_index[COUNT_BITS-1:0]] <= sda_in;
                end else begin
                    miso_data.bytes.low[read_index[COUNT_BITS-1:0]] <= sda_in;
                end
            end
        end
    end

endmodule

// ==== source/i2c_config.svh ====
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// Device and register geometry
`define I2C_ADDRESS_WIDTH   7
`define I2C_REGISTER_WIDTH  16
`define I2C_DATA_WIDTH      16

// Run-time clock divider
`define I2C_DIVIDER_WIDTH   16

// Every transfer on the bus is whole bytes
`define I2C_BYTE_BITS       8

`endif

// ==== source/i2c_master.sv ====
`include "i2c_config.svh"

module i2c_master (
    input  logic                           clock,
    input  logic                           reset_n,
    input  logic                           enable,
    input  logic                           read_write,
    input  i2c_pkg::dev_address_t          device_address,
    input  logic [`I2C_REGISTER_WIDTH-1:0] register_address,
    input  logic [`I2C_DATA_WIDTH-1:0]     mosi_data,
    input  i2c_pkg::divider_t              divider,
    output logic [`I2C_DATA_WIDTH-1:0]     miso_data,
    output logic                           busy,
    input  logic                           scl_in,
    input  logic                           sda_in,
    output logic                           scl_out,
    output logic                           scl_oe,
    output logic                           sda_out,
    output logic                           sda_oe
);
    import i2c_pkg::*;

    logic                            tick;
    phase_t                          phase;
    logic                            active;
    logic                            wait_scl;
    bit_op_t                         bit_op;
    logic                            tx_bit;
    logic [$clog2(`I2C_BYTE_BITS):0] read_index;
    logic                            rx_bit;

    i2c_phase_timer i2c_phase_timer_i (
        .clock    (clock),
        .reset_n  (reset_n),
        .divider  (divider),
        .active   (active),
        .wait_scl (wait_scl),
        .scl_in   (scl_in),
        .tick     (tick),
        .phase    (phase)
    );

    i2c_sequencer i2c_sequencer_i (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .tick             (tick),
        .phase            (phase),
        .rx_bit           (rx_bit),
        .busy             (busy),
        .active           (active),
        .wait_scl         (wait_scl),
        .bit_op           (bit_op),
        .tx_bit           (tx_bit),
        .read_index       (read_index)
    );

    i2c_bit_engine i2c_bit_engine_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .tick       (tick),
        .phase      (phase),
        .bit_op     (bit_op),
        .tx_bit     (tx_bit),
        .read_index (read_index),
        .sda_in     (sda_in),
        .scl_level  (scl_out),
        .scl_oe     (scl_oe),
        .sda_level  (sda_out),
        .sda_oe     (sda_oe),
        .rx_bit     (rx_bit),
        .miso_data  (miso_data)
    );

endmodule

// ==== source/i2c_phase_timer.sv ====
module i2c_phase_timer (
    input  logic              clock,
    input  logic              reset_n,
    input  i2c_pkg::divider_t divider,
    input  logic              active,
    input  logic              wait_scl,
    input  logic              scl_in,
    output logic              tick,
    output i2c_pkg::phase_t   phase
);
    import i2c_pkg::*;

    divider_t count;
    logic     stretched;

    assign tick = (count == divider);

    // Clock released by the master but still held low by the slave
    assign stretched = wait_scl && !scl_in;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= '0;
        end else if (!active || tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            phase <= 2'd0;
        end else if (!active) begin
            phase <= 2'd0;
        end else if (tick) begin
            if (!(phase == 2'd1 && stretched)) begin
                phase <= phase + 2'd1;
            end
        end
    end

endmodule

// ==== source/i2c_pkg.sv ====
`include "i2c_config.svh"

package i2c_pkg;

    typedef logic [`I2C_ADDRESS_WIDTH-1:0] dev_address_t;
    typedef logic [`I2C_DIVIDER_WIDTH-1:0] divider_t;
    typedef logic [1:0]                    phase_t;

    // Register address and data words go out high byte first
    typedef union packed {
        logic [`I2C_DATA_WIDTH-1:0] word;
        struct packed {
            logic [`I2C_BYTE_BITS-1:0] high;
            logic [`I2C_BYTE_BITS-1:0] low;
        } bytes;
    } byte_word_t;

    typedef enum logic [14:0] {
        SEQ_IDLE          = 15'b000_0000_0000_0001,
        SEQ_START         = 15'b000_0000_0000_0010,
        SEQ_ADDRESS_WRITE = 15'b000_0000_0000_0100,
        SEQ_CHECK_ACK     = 15'b000_0000_0000_1000,
        SEQ_REGISTER_HIGH = 15'b000_0000_0001_0000,
        SEQ_REGISTER_LOW  = 15'b000_0000_0010_0000,
        SEQ_DATA_HIGH     = 15'b000_0000_0100_0000,
        SEQ_DATA_LOW      = 15'b000_0000_1000_0000,
        SEQ_RESTART       = 15'b000_0001_0000_0000,
        SEQ_ADDRESS_READ  = 15'b000_0010_0000_0000,
        SEQ_READ_HIGH     = 15'b000_0100_0000_0000,
        SEQ_SEND_ACK      = 15'b000_1000_0000_0000,
        SEQ_READ_LOW      = 15'b001_0000_0000_0000,
        SEQ_SEND_NACK     = 15'b010_0000_0000_0000,
        SEQ_STOP          = 15'b100_0000_0000_0000
    } seq_state_t;

    typedef enum logic [2:0] {
        OP_HOLD,
        OP_START,
        OP_RESTART,
        OP_SEND,
        OP_RECEIVE,
        OP_MASTER_ACK,
        OP_MASTER_NACK,
        OP_STOP
    } bit_op_t;

endpackage

// ==== source/i2c_sequencer.sv ====
`include "i2c_config.svh"

module i2c_sequencer (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            enable,
    input  logic                            read_write,
    input  i2c_pkg::dev_address_t           device_address,
    input  i2c_pkg::byte_word_t             register_address,
    input  i2c_pkg::byte_word_t             mosi_data,
    input  logic                            tick,
    input  i2c_pkg::phase_t                 phase,
    input  logic                            rx_bit,
    output logic                            busy,
    output logic                            active,
    output logic                            wait_scl,
    output i2c_pkg::bit_op_t                bit_op,
    output logic                            tx_bit,
    output logic [$clog2(`I2C_BYTE_BITS):0] read_index
);
    import i2c_pkg::*;

    localparam int COUNT_BITS = $clog2(`I2C_BYTE_BITS);
    localparam logic [COUNT_BITS-1:0] LAST_BIT = COUNT_BITS'(`I2C_BYTE_BITS - 1);

    seq_state_t                state;
    seq_state_t                return_state;
    seq_state_t                next_state;
    seq_state_t                next_return;
    logic [COUNT_BITS-1:0]     bit_count;
    logic                      byte_state;
    logic                      bit_end;
    logic [`I2C_BYTE_BITS-1:0] tx_byte;

    dev_address_t              device_q;
    logic                      read_write_q;
    byte_word_t                register_q;
    byte_word_t                mosi_q;

    // A bus bit ends on the tick that closes phase 3
    assign bit_end = tick && (phase == 2'd3);
    assign active = (state != SEQ_IDLE);
    assign busy = active;

    // Start and restart raise the clock themselves and never wait on it
    assign wait_scl = (bit_op != OP_START) && (bit_op != OP_RESTART);

    // Bits go out MSB first, counted down from LAST_BIT
    assign tx_bit = tx_byte[bit_count];
    assign read_index = {state == SEQ_READ_HIGH, bit_count};

    ////////////////////////////////////////////////////////////////////////////
    // Per-state bus operation and successor
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        bit_op = OP_SEND;
        tx_byte = '1;
        byte_state = 1'b1;
        next_state = SEQ_CHECK_ACK;
        next_return = return_state;
        case (state)
            SEQ_START: begin
                bit_op = OP_START;
                byte_state = 1'b0;
                next_state = return_state;
            end
            SEQ_ADDRESS_WRITE: begin
                tx_byte = {device_q, 1'b0};
                next_return = SEQ_REGISTER_HIGH;
            end
            SEQ_CHECK_ACK: begin
                byte_state = 1'b0;
                // No acknowledge, drop both lines and give up
                next_state = rx_bit ? SEQ_IDLE : return_state;
            end
            SEQ_REGISTER_HIGH: begin
                tx_byte = register_q.bytes.high;
                next_return = SEQ_REGISTER_LOW;
            end
            SEQ_REGISTER_LOW: begin
                tx_byte = register_q.bytes.low;
                next_return = read_write_q ? SEQ_RESTART : SEQ_DATA_HIGH;
            end
            SEQ_DATA_HIGH: begin
                tx_byte = mosi_q.bytes.high;
                next_return = SEQ_DATA_LOW;
            end
            SEQ_DATA_LOW: begin
                tx_byte = mosi_q.bytes.low;
                next_return = SEQ_STOP;
            end
            SEQ_RESTART: begin
                bit_op = OP_RESTART;
                byte_state = 1'b0;
                next_state = SEQ_START;
                next_return = SEQ_ADDRESS_READ;
            end
            SEQ_ADDRESS_READ: begin
                tx_byte = {device_q, 1'b1};
                next_return = SEQ_READ_HIGH;
            end
            SEQ_READ_HIGH: begin
                bit_op = OP_RECEIVE;
                next_state = SEQ_SEND_ACK;
            end
            SEQ_SEND_ACK: begin
                bit_op = OP_MASTER_ACK;
                byte_state = 1'b0;
                next_state = SEQ_READ_LOW;
            end
            SEQ_READ_LOW: begin
                bit_op = OP_RECEIVE;
                next_state = SEQ_SEND_NACK;
            end
            SEQ_SEND_NACK: begin
                bit_op = OP_MASTER_NACK;
                byte_state = 1'b0;
                next_state = SEQ_STOP;
            end
            SEQ_STOP: begin
                bit_op = OP_STOP;
                byte_state = 1'b0;
                next_state = SEQ_IDLE;
            end
            default: begin
                bit_op = OP_HOLD;
                byte_state = 1'b0;
                next_state = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= SEQ_IDLE;
            return_state <= SEQ_IDLE;
            bit_count <= LAST_BIT;
        end else if (state == SEQ_IDLE) begin
            bit_count <= LAST_BIT;
            if (enable) begin
                state <= SEQ_START;
                return_state <= SEQ_ADDRESS_WRITE;
            end
        end else if (bit_end) begin
            if (byte_state && bit_count != '0) begin
                bit_count <= bit_count - 1'b1;
            end else begin
                bit_count <= LAST_BIT;
                state <= next_state;
                return_state <= next_return;
            end
        end
    end

    // Request is frozen for the whole transaction
    always_ff @(posedge clock) begin
        if (state == SEQ_IDLE && enable) begin
            device_q <= device_address;
            read_write_q <= read_write;
            register_q <= register_address;
            mosi_q <= mosi_data;
        end
    end

endmodule

// ==== test/i2c_master_props.sv ====
module i2c_master_props (
    input logic                clock,
    input logic                reset_n,
    input logic                busy,
    input logic                scl_in,
    input logic                scl_oe,
    input logic                sda_oe,
    input i2c_pkg::bit_op_t    bit_op
);
    import i2c_pkg::*;

    // Data may only be pulled low under a high clock for start or stop
    sda_fall_under_clock: assert property (@(posedge clock) disable iff (!reset_n)
        ($rose(sda_oe) && !scl_oe && scl_in) |->
        (bit_op == OP_START || bit_op == OP_STOP ||
         $past(bit_op) == OP_START || $past(bit_op) == OP_STOP))
        else $error("data line pulled low while the clock was high");

    // An idle master lets go of both lines
    idle_lines_released: assert property (@(posedge clock) disable iff (!reset_n)
        !busy |=> (!scl_oe && !sda_oe))
        else $error("line enable set while the master was idle");

    reset_releases_lines: assert property (@(posedge clock)
        !reset_n |=> (!scl_oe && !sda_oe))
        else $error("line enable set during reset");

endmodule

bind i2c_master i2c_master_props i2c_master_props_i (
    .clock   (clock),
    .reset_n (reset_n),
    .busy    (busy),
    .scl_in  (scl_in),
    .scl_oe  (scl_oe),
    .sda_oe  (sda_oe),
    .bit_op  (bit_op)
);

// ==== test/i2c_master_tb.sv ====
module i2c_master_tb;
    import i2c_pkg::*;

    localparam int          TEST_COUNT    = 60;
    localparam int          MAX_DIVIDER   = 9;
    localparam logic [31:0] SEED          = 32'h4f76_129b;
    localparam logic [6:0]  SLAVE_ADDRESS = 7'h2a;
    // Eighty bits of four ticks each per test and twice that for stretching
    localparam int WATCHDOG_TIME = TEST_COUNT * 80 * (MAX_DIVIDER + 1) * 4 * 8 * 2;

    logic         clock;
    logic         reset_n;
    logic         enable;
    logic         read_write;
    dev_address_t device_address;
    logic [15:0]  register_address;
    logic [15:0]  mosi_data;
    divider_t     divider;
    logic [15:0]  miso_data;
    logic         busy;
    logic         scl_out;
    logic         scl_oe;
    logic         sda_out;
    logic         sda_oe;
    logic         scl_hold;
    logic         sda_low;
    logic         scl_line;
    logic         sda_line;
    logic [7:0]   stretch_cycles;
    logic [31:0]  rng;
    int           error_count;
    logic [15:0]  model_memory [logic [15:0]];

    // Either side of the open-drain bus pulls a line low
    assign scl_line = !scl_oe && !scl_hold;
    assign sda_line = !sda_oe && !sda_low;

    i2c_master i2c_master_i (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .divider          (divider),
        .miso_data        (miso_data),
        .busy             (busy),
        .scl_in           (scl_line),
        .sda_in           (sda_line),
        .scl_out          (scl_out),
        .scl_oe           (scl_oe),
        .sda_out          (sda_out),
        .sda_oe           (sda_oe)
    );

    i2c_slave_model slave_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .own_address    (SLAVE_ADDRESS),
        .stretch_cycles (stretch_cycles),
        .scl            (scl_line),
        .sda            (sda_line),
        .scl_hold       (scl_hold),
        .sda_low        (sda_low)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = !clock;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout, a transaction never finished");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] model_word(input logic [15:0] address);
        if (model_memory.exists(address)) begin
            return model_memory[address];
        end
        return 16'h0000;
    endfunction

    task automatic stop_run();
        error_count = error_count + 1;
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_word(input string name, input byte_word_t actual,
                              input byte_word_t expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // Line outputs are registered one clock behind the sequencer
    task automatic check_lines_released();
        @(negedge clock);
        check_level("scl_oe", scl_oe, 1'b0);
        check_level("sda_oe", sda_oe, 1'b0);
        check_level("scl_out", scl_out, 1'b1);
        check_level("sda_out", sda_out, 1'b1);
    endtask

    // Hold one request for a single cycle and wait for busy to fall
    task automatic run_transaction(input logic rw, input logic [6:0] address,
                                   input logic [15:0] register, input logic [15:0] data);
        @(negedge clock);
        read_write = rw;
        device_address = address;
        register_address = register;
        mosi_data = data;
        enable = 1'b1;
        @(negedge clock);
        enable = 1'b0;
        check_level("busy", busy, 1'b1);
        while (busy) begin
            @(negedge clock);
        end
    endtask

    initial begin
        logic [15:0] pool [8];
        logic [7:0]  expected [$];
        logic [31:0] draw;
        logic [15:0] register;
        logic [15:0] data;
        logic [6:0]  address;
        int          log_start;
        int          stops_before;

        reset_n = 1'b0;
        enable = 1'b0;
        read_write = 1'b0;
        device_address = '0;
        register_address = '0;
        mosi_data = '0;
        divider = 16'd2;
        stretch_cycles = 8'd0;
        error_count = 0;
        rng = SEED;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        check_level("busy", busy, 1'b0);
        check_level("scl_oe", scl_oe, 1'b0);
        check_level("sda_oe", sda_oe, 1'b0);
        check_word("miso_data", miso_data, 16'h0000);
        check_lines_released();

        // Small address pool so that reads hit earlier writes
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            pool[i] = rng[15:0];
        end

        for (int t = 0; t < TEST_COUNT; t++) begin
            rng = xorshift32(rng);
            draw = rng;
            register = pool[draw[2:0]];
            rng = xorshift32(rng);
            data = rng[15:0];
            divider = 16'd2 + 16'(rng[31:16] % 16'd8);
            rng = xorshift32(rng);
            stretch_cycles = (rng[3:0] < 4'd6) ? 8'd0 : 8'(rng[11:4] % 8'd20);
            log_start = slave_i.received.size();
            stops_before = slave_i.stop_count;
            expected.delete();

            if (draw[7:5] == 3'd0) begin
                address = SLAVE_ADDRESS ^ 7'(1 + rng[22:16] % 7'd127);
                run_transaction(draw[8], address, register, data);
                check_level("log_unchanged", slave_i.received.size() == log_start, 1'b1);
                check_level("no_stop", slave_i.stop_count == stops_before, 1'b1);
                check_lines_released();
                check_word("memory", slave_i.stored_word(register), model_word(register));
            end else if (draw[8]) begin
                run_transaction(1'b1, SLAVE_ADDRESS, register, data);
                expected = '{{SLAVE_ADDRESS, 1'b0}, register[15:8], register[7:0],
                             {SLAVE_ADDRESS, 1'b1}};
                check_level("log_length", slave_i.received.size() == log_start + 4, 1'b1);
                foreach (expected[i]) begin
                    check_byte("read_request_byte", slave_i.received[log_start + i],
                               expected[i]);
                end
                check_level("stop_seen", slave_i.stop_count == stops_before + 1, 1'b1);
                check_word("miso_data", miso_data, model_word(register));
                check_lines_released();
            end else begin
                run_transaction(1'b0, SLAVE_ADDRESS, register, data);
                model_memory[register] = data;
                expected = '{{SLAVE_ADDRESS, 1'b0}, register[15:8], register[7:0],
                             data[15:8], data[7:0]};
                check_level("log_length", slave_i.received.size() == log_start + 5, 1'b1);
                foreach (expected[i]) begin
                    check_byte("write_byte", slave_i.received[log_start + i], expected[i]);
                end
                check_level("stop_seen", slave_i.stop_count == stops_before + 1, 1'b1);
                check_word("memory", slave_i.stored_word(register), data);
                check_lines_released();
            end
        end

        foreach (model_memory[k]) begin
            check_word("final_memory", slave_i.stored_word(k), model_memory[k]);
        end

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/i2c_slave_model.sv ====
module i2c_slave_model (
    input  logic       clock,
    input  logic       reset_n,
    input  logic [6:0] own_address,
    input  logic [7:0] stretch_cycles,
    input  logic       scl,
    input  logic       sda,
    output logic       scl_hold,
    output logic       sda_low
);
    localparam logic [1:0] MODE_IDLE    = 2'd0;
    localparam logic [1:0] MODE_RECEIVE = 2'd1;
    localparam logic [1:0] MODE_SEND    = 2'd2;

    logic [15:0] memory [logic [15:0]];
    logic [7:0]  received [$];
    int          stop_count;

    logic        scl_q;
    logic        sda_q;
    logic [1:0]  mode;
    logic [3:0]  bit_count;
    logic [7:0]  shift;
    logic [7:0]  data_high;
    logic [15:0] pointer;
    logic [15:0] read_word;
    logic [7:0]  stretch_left;
    logic        reading;
    logic        sending_low;
    logic        master_ack;
    int          byte_index;

    function automatic logic [15:0] stored_word(input logic [15:0] address);
        if (memory.exists(address)) begin
            return memory[address];
        end
        return 16'h0000;
    endfunction

    // Register file behind a 16-bit pointer, address byte first
    task automatic accept_byte();
        logic ack;
        ack = 1'b1;
        case (byte_index)
            0: begin
                ack = (shift[7:1] == own_address);
                reading = shift[0];
            end
            1: pointer[15:8] = shift;
            2: pointer[7:0] = shift;
            3: data_high = shift;
            4: memory[pointer] = {data_high, shift};
            default: ack = 1'b1;
        endcase
        if (ack) begin
            received.push_back(shift);
            byte_index = byte_index + 1;
            sda_low <= 1'b1;
        end else begin
            mode = MODE_IDLE;
        end
    endtask

    always @(posedge clock) begin
        if (!reset_n) begin
            scl_q = 1'b1;
            sda_q = 1'b1;
            mode = MODE_IDLE;
            bit_count = 4'd0;
            byte_index = 0;
            stretch_left = 8'd0;
            reading = 1'b0;
            stop_count = 0;
            scl_hold <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            if (stretch_left != 8'd0) begin
                if (stretch_left == 8'd1) begin
                    scl_hold <= 1'b0;
                end
                stretch_left = stretch_left - 8'd1;
            end
            if (scl_q && scl && sda_q && !sda) begin
                // Start or repeated start
                mode = MODE_RECEIVE;
                bit_count = 4'd0;
                byte_index = 0;
                reading = 1'b0;
                sda_low <= 1'b0;
            end else if (scl_q && scl && !sda_q && sda) begin
                mode = MODE_IDLE;
                stop_count = stop_count + 1;
                sda_low <= 1'b0;
            end else if (!scl_q && scl) begin
                if (mode == MODE_RECEIVE && bit_count < 4'd8) begin
                    shift = {shift[6:0], sda};
                    bit_count = bit_count + 4'd1;
                end else if (mode == MODE_SEND && bit_count < 4'd8) begin
                    bit_count = bit_count + 4'd1;
                end else if (mode != MODE_IDLE && bit_count == 4'd8) begin
                    master_ack = !sda;
                    bit_count = 4'd9;
                end
            end else if (scl_q && !scl && mode != MODE_IDLE) begin
                if (bit_count == 4'd4 && stretch_cycles != 8'd0) begin
                    scl_hold <= 1'b1;
                    stretch_left = stretch_cycles;
                end
                if (mode == MODE_RECEIVE) begin
                    if (bit_count == 4'd8) begin
                        accept_byte();
                    end else if (bit_count == 4'd9) begin
                        sda_low <= 1'b0;
                        bit_count = 4'd0;
                        if (reading) begin
                            mode = MODE_SEND;
                            read_word = stored_word(pointer);
                            shift = read_word[15:8];
                            sending_low = 1'b0;
                            sda_low <= !shift[7];
                        end
                    end
                end else begin
                    if (bit_count >= 4'd1 && bit_count <= 4'd7) begin
                        sda_low <= !shift[3'd7 - bit_count[2:0]];
                    end else if (bit_count == 4'd8) begin
                        sda_low <= 1'b0;
                    end else if (bit_count == 4'd9) begin
                        if (master_ack && !sending_low) begin
                            shift = read_word[7:0];
                            sending_low = 1'b1;
                            bit_count = 4'd0;
                            sda_low <= !shift[7];
                        end else begin
                            mode = MODE_IDLE;
                            sda_low <= 1'b0;
                        end
                    end
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule
